// ==== design/segment_chase_pkg.sv ====
package segment_chase_pkg;

    localparam int NUM_SEGS = 7;
    localparam int NUM_BUTTONS = 4;
    localparam int DEBOUNCE_LEN = 4;

    // Half-second tick on the board clock
    localparam int TICK_DIV_BITS_DEFAULT = 26;

    // Roughly three seconds of idle
    localparam int IDLE_TICKS = 6;
    localparam int IDLE_CNT_W = $clog2(IDLE_TICKS);

    typedef enum logic [2:0] {
        SEG_A,
        SEG_B,
        SEG_C,
        SEG_D,
        SEG_E,
        SEG_F,
        SEG_G
    } seg_idx_t;

    typedef enum logic [1:0] {
        HEAD_RIGHT,
        HEAD_LEFT,
        HEAD_UP,
        HEAD_DOWN
    } heading_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MOVING,
        ST_SWEEP
    } game_state_t;

    // Active low with bit i driving segment i
    typedef logic [NUM_SEGS-1:0] seg_word_t;

    localparam seg_idx_t START_SEG = SEG_G;
    localparam heading_t START_HEAD = HEAD_LEFT;

    // Rightmost digit only
    localparam logic [3:0] DIGIT_ENABLE = 4'b1110;
    localparam seg_word_t SEGS_DARK = '1;
    localparam seg_word_t SEGS_IDLE = 7'b0111111;

endpackage

// ==== design/btn_if.sv ====
`timescale 1ns/1ps

// One-cycle button strobes after debounce
interface btn_if;
    logic right;
    logic left;
    logic up;
    logic down;

    modport source (
        output right,
        output left,
        output up,
        output down
    );

    modport sink (
        input right,
        input left,
        input up,
        input down
    );
endinterface

// ==== design/button_bank.sv ====
`timescale 1ns/1ps

module button_bank import segment_chase_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  raw_right,
    input  logic  raw_left,
    input  logic  raw_up,
    input  logic  raw_down,
    btn_if.source btn
);

    logic [NUM_BUTTONS-1:0]  raw;
    logic [DEBOUNCE_LEN-1:0] shift [NUM_BUTTONS];
    logic [NUM_BUTTONS-1:0]  level;
    logic [NUM_BUTTONS-1:0]  level_d;
    logic [NUM_BUTTONS-1:0]  pulse;

    assign raw = {raw_down, raw_up, raw_left, raw_right};

    // Debounced level needs every sample high
    always_comb begin
        for (int i = 0; i < NUM_BUTTONS; i++) begin
            level[i] = &shift[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                shift[i] <= '0;
            end
            level_d <= '0;
            pulse   <= '0;
        end else begin
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                shift[i] <= {shift[i][DEBOUNCE_LEN-2:0], raw[i]};
            end
            level_d <= level;
            pulse   <= level & ~level_d;
        end
    end

    assign btn.right = pulse[0];
    assign btn.left  = pulse[1];
    assign btn.up    = pulse[2];
    assign btn.down  = pulse[3];

endmodule

// ==== design/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen import segment_chase_pkg::*; #(
    parameter int DIV_BITS = TICK_DIV_BITS_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [DIV_BITS-1:0] count;

    // Tick follows the cycle where the counter wraps
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            count <= count + 1'b1;
            tick  <= &count;
        end
    end

endmodule

// ==== design/segment_walker.sv ====
`timescale 1ns/1ps

module segment_walker import segment_chase_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    btn_if.sink         btn,
    input  game_state_t state,
    input  logic        load,
    output seg_idx_t    pos,
    output logic        moved
);

    heading_t heading;
    logic     active;

    // {hit, new segment, new heading}
    logic [5:0] step;

    assign active = (state == ST_MOVING) || (state == ST_SWEEP);

    // Move table with no entry for down
    always_comb begin
        step = {1'b0, pos, heading};
        case (pos)
            SEG_A: begin
                if (heading == HEAD_RIGHT && btn.right) step = {1'b1, SEG_B, HEAD_DOWN};
                else if (heading == HEAD_LEFT && btn.left) step = {1'b1, SEG_F, HEAD_DOWN};
            end
            SEG_B: begin
                if (heading == HEAD_UP && btn.left) step = {1'b1, SEG_A, HEAD_LEFT};
                else if (heading == HEAD_DOWN && btn.right) step = {1'b1, SEG_G, HEAD_LEFT};
                else if (heading == HEAD_DOWN && btn.up) step = {1'b1, SEG_C, HEAD_DOWN};
            end
            SEG_C: begin
                if (heading == HEAD_UP && btn.left) step = {1'b1, SEG_G, HEAD_LEFT};
                else if (heading == HEAD_UP && btn.up) step = {1'b1, SEG_B, HEAD_UP};
                else if (heading == HEAD_DOWN && btn.right) step = {1'b1, SEG_D, HEAD_DOWN};
            end
            SEG_D: begin
                if (heading == HEAD_RIGHT && btn.left) step = {1'b1, SEG_C, HEAD_UP};
                else if (heading == HEAD_LEFT && btn.right) step = {1'b1, SEG_E, HEAD_UP};
            end
            SEG_E: begin
                if (heading == HEAD_UP && btn.right) step = {1'b1, SEG_G, HEAD_RIGHT};
                else if (heading == HEAD_UP && btn.up) step = {1'b1, SEG_F, HEAD_UP};
                else if (heading == HEAD_DOWN && btn.left) step = {1'b1, SEG_D, HEAD_RIGHT};
            end
            SEG_F: begin
                if (heading == HEAD_UP && btn.right) step = {1'b1, SEG_A, HEAD_RIGHT};
                else if (heading == HEAD_DOWN && btn.left) step = {1'b1, SEG_G, HEAD_RIGHT};
            end
            SEG_G: begin
                if (heading == HEAD_RIGHT && btn.left) step = {1'b1, SEG_B, HEAD_UP};
                else if (heading == HEAD_RIGHT && btn.right) step = {1'b1, SEG_C, HEAD_DOWN};
                else if (heading == HEAD_LEFT && btn.left) step = {1'b1, SEG_E, HEAD_DOWN};
                else if (heading == HEAD_LEFT && btn.right) step = {1'b1, SEG_F, HEAD_UP};
            end
            default: step = {1'b0, pos, heading};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos     <= START_SEG;
            heading <= START_HEAD;
            moved   <= 1'b0;
        end else if (load) begin
            pos     <= START_SEG;
            heading <= START_HEAD;
            moved   <= 1'b0;
        end else if (active && step[5]) begin
            pos     <= seg_idx_t'(step[4:2]);
            heading <= heading_t'(step[1:0]);
            moved   <= 1'b1;
        end else begin
            moved   <= 1'b0;
        end
    end

endmodule

// ==== design/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm import segment_chase_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                tick,
    btn_if.sink                 btn,
    input  seg_idx_t            pos,
    input  logic                moved,
    output game_state_t         state,
    output logic                load,
    output logic [NUM_SEGS-1:0] visited
);

    logic [IDLE_CNT_W-1:0] idle_cnt;
    logic                  idle_done;
    logic [NUM_SEGS-1:0]   pos_bit;

    assign idle_done = (idle_cnt == IDLE_CNT_W'(IDLE_TICKS - 1));

    // Walker reloads on the same edge that enters moving
    assign load = (state == ST_IDLE) && tick && idle_done;

    assign pos_bit = {{(NUM_SEGS-1){1'b0}}, 1'b1} << pos;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            idle_cnt <= '0;
            visited  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (tick) begin
                        if (idle_done) begin
                            state    <= ST_MOVING;
                            idle_cnt <= '0;
                        end else begin
                            idle_cnt <= idle_cnt + 1'b1;
                        end
                    end
                end
                ST_MOVING: begin
                    // Sweep starts with only the current segment visited
                    if (btn.down) begin
                        state   <= ST_SWEEP;
                        visited <= pos_bit;
                    end
                end
                ST_SWEEP: begin
                    if (tick && (&visited)) begin
                        state   <= ST_IDLE;
                        visited <= '0;
                    end else if (moved) begin
                        visited <= visited | pos_bit;
                    end
                end
                default: begin
                    state    <= ST_IDLE;
                    idle_cnt <= '0;
                    visited  <= '0;
                end
            endcase
        end
    end

endmodule

// ==== design/seg_display.sv ====
`timescale 1ns/1ps

module seg_display import segment_chase_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                tick,
    input  game_state_t         state,
    input  seg_idx_t            pos,
    input  logic [NUM_SEGS-1:0] visited,
    output seg_word_t           segments
);

    logic      blink;
    seg_word_t word;

    always_comb begin
        word = SEGS_DARK;
        case (state)
            ST_IDLE:   word = SEGS_IDLE;
            ST_MOVING: word[pos] = 1'b0;
            ST_SWEEP: begin
                word      = ~visited;
                // Current segment goes dark on odd blink phase
                word[pos] = blink;
            end
            default:   word = SEGS_DARK;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blink    <= 1'b0;
            segments <= SEGS_IDLE;
        end else begin
            if (state != ST_SWEEP) begin
                blink <= 1'b0;
            end else if (tick) begin
                blink <= ~blink;
            end
            segments <= word;
        end
    end

endmodule

// ==== design/segment_chase_top.sv ====
`timescale 1ns/1ps

module segment_chase_top import segment_chase_pkg::*; #(
    parameter int TICK_DIV_BITS = TICK_DIV_BITS_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       right,
    input  logic       left,
    input  logic       up,
    input  logic       down,
    output logic [3:0] digit,
    output seg_word_t  segments
);

    logic                tick;
    game_state_t         state;
    logic                load;
    seg_idx_t            pos;
    logic                moved;
    logic [NUM_SEGS-1:0] visited;

    btn_if btn ();

    button_bank u_button_bank (
        .clk       (clk),
        .rst       (rst),
        .raw_right (right),
        .raw_left  (left),
        .raw_up    (up),
        .raw_down  (down),
        .btn       (btn)
    );

    tick_gen #(
        .DIV_BITS (TICK_DIV_BITS)
    ) u_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    segment_walker u_segment_walker (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn),
        .state (state),
        .load  (load),
        .pos   (pos),
        .moved (moved)
    );

    game_fsm u_game_fsm (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .btn     (btn),
        .pos     (pos),
        .moved   (moved),
        .state   (state),
        .load    (load),
        .visited (visited)
    );

    seg_display u_seg_display (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .state    (state),
        .pos      (pos),
        .visited  (visited),
        .segments (segments)
    );

    assign digit = DIGIT_ENABLE;

endmodule

// ==== tests/segment_chase_tb.sv ====
`timescale 1ns/1ps

module segment_chase_tb import segment_chase_pkg::*; ();

    localparam int TICK_BITS = 4;
    localparam int TICK_CYCLES = 1 << TICK_BITS;
    localparam int IDLE_WAIT = 7 * TICK_CYCLES + 10;
    localparam int STEP_MAX = 8 + 6 + TICK_CYCLES;
    localparam int NUM_STEPS = 16;
    localparam int MAX_CYCLES = 4 * (IDLE_WAIT + NUM_STEPS * STEP_MAX + 4 * TICK_CYCLES);
    localparam seg_word_t IDLE_WORD = 7'b0111111;

    localparam int B_RIGHT = 0;
    localparam int B_LEFT = 1;
    localparam int B_UP = 2;
    localparam int B_DOWN = 3;

    localparam int M_IDLE = 0;
    localparam int M_MOVING = 1;
    localparam int M_SWEEP = 2;

    logic       clk = 1'b0;
    logic       rst;
    logic       right;
    logic       left;
    logic       up;
    logic       down;
    logic [3:0] digit;
    seg_word_t  segments;

    integer seed = 32'hc5738ce6;
    int     cycles = 0;
    int     passed = 0;
    int     failed = 0;

    // Step table of button, hold and expected segment
    // Zero hold picks a random valid length
    int       step_btn [$];
    int       step_hold [$];
    seg_idx_t step_seg [$];

    segment_chase_top #(
        .TICK_DIV_BITS (TICK_BITS)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .right    (right),
        .left     (left),
        .up       (up),
        .down     (down),
        .digit    (digit),
        .segments (segments)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic add_step(input int which, input int hold, input seg_idx_t seg);
        step_btn.push_back(which);
        step_hold.push_back(hold);
        step_seg.push_back(seg);
    endtask

    task automatic drive_button(input int which, input logic value);
        case (which)
            B_RIGHT: right = value;
            B_LEFT:  left = value;
            B_UP:    up = value;
            default: down = value;
        endcase
    endtask

    task automatic press(input int which, input int hold);
        @(negedge clk);
        drive_button(which, 1'b1);
        repeat (hold) @(negedge clk);
        drive_button(which, 1'b0);
        repeat (6) @(negedge clk);
    endtask

    task automatic report(input string name, input logic ok);
        if (ok) begin
            passed++;
            $display("%s: PASS", name);
        end else begin
            failed++;
            $display("%s: FAIL", name);
        end
    endtask

    // Compare only the bits set in mask
    task automatic check_word(input string name, input seg_word_t exp, input seg_word_t mask);
        if ((segments & mask) !== (exp & mask)) begin
            $display("[ERROR] %0t segments: expected %b got %b (care mask %b)",
                     $time, exp, segments, mask);
            report(name, 1'b0);
        end else begin
            report(name, 1'b1);
        end
    endtask

    // Active-low display rules
    function automatic seg_word_t model_word(input int mode, input seg_idx_t p,
                                             input logic [6:0] vis);
        seg_word_t w;
        w = '1;
        if (mode == M_IDLE) begin
            w[6] = 1'b0;
        end else if (mode == M_MOVING) begin
            w[p] = 1'b0;
        end else begin
            w = ~vis;
        end
        return w;
    endfunction

    initial begin
        seg_idx_t   exp_pos;
        logic [6:0] exp_vis;
        seg_word_t  mask;
        seg_word_t  first;
        int         mode;
        int         hold;
        int         waited;
        logic       entered;

        rst = 1'b1;
        right = 1'b0;
        left = 1'b0;
        up = 1'b0;
        down = 1'b0;

        // Moving walk and dead presses before the sweep and tour
        add_step(B_RIGHT, 0, SEG_F);
        add_step(B_RIGHT, 0, SEG_A);
        add_step(B_LEFT,  0, SEG_A);
        add_step(B_RIGHT, 0, SEG_B);
        add_step(B_RIGHT, 0, SEG_G);
        add_step(B_UP,    0, SEG_G);
        add_step(B_LEFT,  2, SEG_G);
        add_step(B_DOWN,  0, SEG_G);
        add_step(B_DOWN,  0, SEG_G);
        add_step(B_LEFT,  0, SEG_E);
        add_step(B_LEFT,  0, SEG_D);
        add_step(B_LEFT,  0, SEG_C);
        add_step(B_UP,    0, SEG_B);
        add_step(B_LEFT,  0, SEG_A);
        add_step(B_LEFT,  0, SEG_F);
        // Game is back in idle and ignores this press
        add_step(B_LEFT,  0, SEG_G);

        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (digit !== 4'b1110) begin
            $display("[ERROR] %0t digit: expected %b got %b", $time, 4'b1110, digit);
            report("digit", 1'b0);
        end else begin
            report("digit", 1'b1);
        end
        check_word("reset", IDLE_WORD, '1);

        repeat (IDLE_WAIT) @(negedge clk);
        mode = M_MOVING;
        exp_pos = SEG_G;
        exp_vis = '0;

        for (int i = 0; i < step_btn.size(); i++) begin
            hold = (step_hold[i] != 0) ? step_hold[i] : 4 + ($unsigned($random(seed)) % 5);
            press(step_btn[i], hold);
            entered = 1'b0;
            if (mode == M_MOVING && step_btn[i] == B_DOWN) begin
                mode = M_SWEEP;
                exp_vis = '0;
                exp_vis[exp_pos] = 1'b1;
                entered = 1'b1;
            end else if (mode != M_IDLE) begin
                exp_pos = step_seg[i];
                if (mode == M_SWEEP) begin
                    exp_vis[exp_pos] = 1'b1;
                end
            end

            if (mode == M_SWEEP && (&exp_vis)) begin
                waited = 0;
                while (segments !== IDLE_WORD && waited < 2 * TICK_CYCLES + 4) begin
                    @(negedge clk);
                    waited++;
                end
                mode = M_IDLE;
                if (segments !== IDLE_WORD) begin
                    $display("Step %0d: game did not return to idle within two ticks", i);
                    report($sformatf("step %0d", i), 1'b0);
                end else begin
                    report($sformatf("step %0d", i), 1'b1);
                end
            end else begin
                repeat (TICK_CYCLES) @(negedge clk);
                mask = '1;
                if (mode == M_SWEEP) begin
                    mask[exp_pos] = 1'b0;
                end
                check_word($sformatf("step %0d", i), model_word(mode, exp_pos, exp_vis), mask);
            end

            // Blink phase must flip across one tick
            if (entered) begin
                first = segments;
                repeat (TICK_CYCLES) @(negedge clk);
                if (first[5:0] !== 6'h3f || segments !== {~first[6], 6'h3f}) begin
                    $display("[ERROR] %0t segments: expected %b then %b got %b then %b",
                             $time, {first[6], 6'h3f}, {~first[6], 6'h3f}, first, segments);
                    report("sweep blink", 1'b0);
                end else begin
                    report("sweep blink", 1'b1);
                end
            end
        end

        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/segment_chase_pkg.sv
design/btn_if.sv
design/button_bank.sv
design/tick_gen.sv
design/segment_walker.sv
design/game_fsm.sv
design/seg_display.sv
design/segment_chase_top.sv
tests/segment_chase_tb.sv
